// File: include/rvCore_defs.svh
// Core-wide constants for the RV32I core; include wherever the reset vector or widths are needed
`ifndef RVCORE_DEFS_SVH
`define RVCORE_DEFS_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Datapath and address width
`define XLEN 32

// Architectural registers, x0 included
`define NUM_REGS 32

`endif

// File: verilog/rvIsaPkg.sv
// ISA-level types for RV32I: words, register indices, opcodes, instruction fields, immediates
`include "rvCore_defs.svh"

package rvIsaPkg;

    // Data or address value
    typedef logic [`XLEN-1:0] wordT;

    // Raw 32-bit instruction word
    typedef logic [31:0] instrT;

    // Register index, x0 to x31
    typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;

    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcodeE;

    // Fixed-position fields of a 32-bit instruction
    typedef struct packed {
        opcodeE opcode;
        regIdxT rd;
        regIdxT rs1;
        regIdxT rs2;
        funct3T funct3;
        funct7T funct7;
    } instrFieldsT;

    // Immediate layouts; SH is the 5-bit shift amount of the immediate shifts
    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_SH,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immFmtE;

endpackage

// File: verilog/rvCorePkg.sv
// Core-level types: control word, ALU selects, Wishbone structs, retire record, sequencer states
package rvCorePkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOpE;

    // First ALU operand source
    typedef enum logic [1:0] {
        SRCA_RS1,
        SRCA_PC,
        SRCA_ZERO
    } aluSrcAE;

    // Register writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wbSrcE;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branch;
        logic    jump;      // JAL and JALR
        logic    jalr;      // JALR only, target comes from the ALU
        logic    halt;
        logic    illegal;
        aluOpE   aluOp;
        aluSrcAE aluSrcA;
        logic    opBImm;
        wbSrcE   wbSrc;
    } ctrlT;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic           cyc;
        logic           stb;
        logic           we;
        rvIsaPkg::wordT adr;
        rvIsaPkg::wordT dat;
        logic [3:0]     sel;
    } wbReqT;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic           ack;
        rvIsaPkg::wordT dat;
    } wbRspT;

    // One record per retired instruction
    typedef struct packed {
        logic             valid;
        rvIsaPkg::wordT   pc;
        rvIsaPkg::instrT  instr;
        logic             rdWe;
        rvIsaPkg::regIdxT rd;
        rvIsaPkg::wordT   rdData;
        logic             illegal;
    } retireT;

    typedef enum logic [2:0] {
        SEQ_FETCH,
        SEQ_DECODE,
        SEQ_EXECUTE,
        SEQ_MEMORY,
        SEQ_WRITEBACK,
        SEQ_HALTED
    } seqStateE;

endpackage

// File: verilog/instrFetch.sv
// Program counter, next-PC selection and Wishbone instruction-bus read master
`include "rvCore_defs.svh"

module instrFetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetchStart,
    input  logic               pcUpdate,
    input  rvCorePkg::ctrlT    ctrl,
    input  rvIsaPkg::wordT     imm,
    input  logic               branchTaken,
    input  rvIsaPkg::wordT     aluResult,
    output rvCorePkg::wbReqT   ibusReq,
    input  rvCorePkg::wbRspT   ibusRsp,
    output rvIsaPkg::wordT     pc,
    output rvIsaPkg::wordT     pcPlus4,
    output rvIsaPkg::instrT    instr,
    output logic               fetchDone
);

    rvIsaPkg::wordT nextPc;
    logic           busy;

    assign pcPlus4 = pc + rvIsaPkg::wordT'(4);

    // JALR target has bit 0 cleared
    always_comb
    begin
        if (ctrl.jalr)
            nextPc = aluResult & ~rvIsaPkg::wordT'(1);
        else if ((ctrl.branch && branchTaken) || ctrl.jump)
            nextPc = pc + imm;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= `RESET_PC;
        else if (pcUpdate)
            pc <= nextPc;
    end

    // Read cycle held open until ack, dropped the cycle after
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            busy <= 1'b0;
        else if (fetchStart)
            busy <= 1'b1;
        else if (fetchDone)
            busy <= 1'b0;
    end

    // Fetched word, taken at ack
    always_ff @(posedge clk)
    begin
        if (fetchDone)
            instr <= ibusRsp.dat;
    end

    assign fetchDone = busy && ibusRsp.ack;

    // PC is stable for the whole cycle, so it drives adr directly
    always_comb
    begin
        ibusReq.cyc = busy;
        ibusReq.stb = busy;
        ibusReq.we  = 1'b0;
        ibusReq.adr = pc;
        ibusReq.dat = '0;
        ibusReq.sel = '1;
    end

    // Open request keeps cyc, stb and the address until ack
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
        ibusReq.stb && !ibusRsp.ack |=> ibusReq.cyc && ibusReq.stb && $stable(ibusReq.adr));

endmodule

// File: verilog/decode.sv
// Instruction register, field split, immediate build and control decode for the RV32I core
module decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  decodeLoad,
    input  rvIsaPkg::instrT       nextInstruction,
    output rvIsaPkg::instrFieldsT fields,
    output rvIsaPkg::wordT        imm,
    output rvCorePkg::ctrlT       ctrl,
    output rvIsaPkg::instrT       instrReg
);

    rvIsaPkg::immFmtE immFmt;
    logic             altOk;

    // Zero after reset, which decodes as illegal
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            instrReg <= '0;
        else if (decodeLoad)
            instrReg <= nextInstruction;
    end

    // Field split straight from the register
    assign fields.opcode = rvIsaPkg::opcodeE'(instrReg[6:0]);
    assign fields.rd     = instrReg[11:7];
    assign fields.funct3 = instrReg[14:12];
    assign fields.rs1    = instrReg[19:15];
    assign fields.rs2    = instrReg[24:20];
    assign fields.funct7 = instrReg[31:25];

    // funct7 must be zero, or 0100000 for SUB, SRA and SRAI
    assign altOk = (fields.funct7 == 7'b0000000) ||
                   (fields.funct7 == 7'b0100000 &&
                    (fields.funct3 == 3'b101 ||
                     (fields.funct3 == 3'b000 && fields.opcode == rvIsaPkg::OP_REG)));

    // ALU operation from funct3 plus the funct7 alternate bit
    function automatic rvCorePkg::aluOpE aluFor(rvIsaPkg::funct3T f3, logic alt);
        case (f3)
            3'b000:  return alt ? rvCorePkg::ALU_SUB : rvCorePkg::ALU_ADD;
            3'b001:  return rvCorePkg::ALU_SLL;
            3'b010:  return rvCorePkg::ALU_SLT;
            3'b011:  return rvCorePkg::ALU_SLTU;
            3'b100:  return rvCorePkg::ALU_XOR;
            3'b101:  return alt ? rvCorePkg::ALU_SRA : rvCorePkg::ALU_SRL;
            3'b110:  return rvCorePkg::ALU_OR;
            default: return rvCorePkg::ALU_AND;
        endcase
    endfunction

    always_comb
    begin
        // No-op defaults
        immFmt       = rvIsaPkg::IMM_NONE;
        ctrl         = '0;
        ctrl.aluOp   = rvCorePkg::ALU_ADD;
        ctrl.aluSrcA = rvCorePkg::SRCA_RS1;
        ctrl.wbSrc   = rvCorePkg::WB_ALU;
        case (fields.opcode)
            rvIsaPkg::OP_LUI:
            begin
                immFmt        = rvIsaPkg::IMM_U;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA  = rvCorePkg::SRCA_ZERO;
                ctrl.opBImm   = 1'b1;
                ctrl.aluOp    = rvCorePkg::ALU_PASSB;
            end
            rvIsaPkg::OP_AUIPC:
            begin
                immFmt        = rvIsaPkg::IMM_U;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA  = rvCorePkg::SRCA_PC;
                ctrl.opBImm   = 1'b1;
            end
            // Link value is PC+4, target built in fetch
            rvIsaPkg::OP_JAL:
            begin
                immFmt        = rvIsaPkg::IMM_J;
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.wbSrc    = rvCorePkg::WB_PC4;
            end
            // ALU forms rs1 + imm as the target
            rvIsaPkg::OP_JALR:
            begin
                immFmt        = rvIsaPkg::IMM_I;
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.jalr     = 1'b1;
                ctrl.opBImm   = 1'b1;
                ctrl.wbSrc    = rvCorePkg::WB_PC4;
            end
            // funct3 010 and 011 are not branches
            rvIsaPkg::OP_BRANCH:
            begin
                immFmt       = rvIsaPkg::IMM_B;
                ctrl.aluOp   = rvCorePkg::ALU_SUB;
                ctrl.illegal = fields.funct3[2:1] == 2'b01;
                ctrl.branch  = !ctrl.illegal;
            end
            // Word accesses only
            rvIsaPkg::OP_LOAD:
            begin
                immFmt        = rvIsaPkg::IMM_I;
                ctrl.opBImm   = 1'b1;
                ctrl.wbSrc    = rvCorePkg::WB_LOAD;
                ctrl.illegal  = fields.funct3 != 3'b010;
                ctrl.memRead  = !ctrl.illegal;
                ctrl.regWrite = !ctrl.illegal;
            end
            rvIsaPkg::OP_STORE:
            begin
                immFmt        = rvIsaPkg::IMM_S;
                ctrl.opBImm   = 1'b1;
                ctrl.illegal  = fields.funct3 != 3'b010;
                ctrl.memWrite = !ctrl.illegal;
            end
            // ADDI never subtracts; shifts check funct7
            rvIsaPkg::OP_IMM:
            begin
                ctrl.opBImm = 1'b1;
                ctrl.aluOp  = aluFor(fields.funct3, fields.funct3 == 3'b101 && fields.funct7[5]);
                if (fields.funct3 == 3'b001 || fields.funct3 == 3'b101)
                begin
                    immFmt       = rvIsaPkg::IMM_SH;
                    ctrl.illegal = !altOk;
                end
                else
                    immFmt = rvIsaPkg::IMM_I;
                ctrl.regWrite = !ctrl.illegal;
            end
            rvIsaPkg::OP_REG:
            begin
                ctrl.aluOp    = aluFor(fields.funct3, fields.funct7[5]);
                ctrl.illegal  = !altOk;
                ctrl.regWrite = !ctrl.illegal;
            end
            // Single hart, nothing to order
            rvIsaPkg::OP_FENCE:
            begin
                ctrl.regWrite = 1'b0;
            end
            // ECALL and EBREAK stop the core, CSR forms are not supported
            rvIsaPkg::OP_SYSTEM:
            begin
                ctrl.halt    = fields.funct3 == 3'b000;
                ctrl.illegal = !ctrl.halt;
            end
            default:
            begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    // Sign-extended immediates
    always_comb
    begin
        case (immFmt)
            rvIsaPkg::IMM_I:  imm = {{20{instrReg[31]}}, instrReg[31:20]};
            rvIsaPkg::IMM_SH: imm = {27'b0, instrReg[24:20]};
            rvIsaPkg::IMM_S:  imm = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
            rvIsaPkg::IMM_B:  imm = {{20{instrReg[31]}}, instrReg[7], instrReg[30:25],
                                     instrReg[11:8], 1'b0};
            rvIsaPkg::IMM_U:  imm = {instrReg[31:12], 12'b0};
            rvIsaPkg::IMM_J:  imm = {{12{instrReg[31]}}, instrReg[19:12], instrReg[20],
                                     instrReg[30:21], 1'b0};
            default:          imm = '0;
        endcase
    end

endmodule

// File: verilog/regFile.sv
// General register file: x1 to x31 with two asynchronous read ports, x0 reads as zero
`include "rvCore_defs.svh"

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  rvIsaPkg::regIdxT rs1,
    input  rvIsaPkg::regIdxT rs2,
    output rvIsaPkg::wordT   rs1Data,
    output rvIsaPkg::wordT   rs2Data,
    input  logic             we,
    input  rvIsaPkg::regIdxT rd,
    input  rvIsaPkg::wordT   wdata
);

    // No storage behind x0
    rvIsaPkg::wordT regs [1:`NUM_REGS-1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)
            regs[rd] <= wdata;
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: verilog/alu.sv
// Combinational ALU: arithmetic, logic, shifts and the six branch comparisons
`include "rvCore_defs.svh"

module alu (
    input  rvIsaPkg::wordT    opA,
    input  rvIsaPkg::wordT    opB,
    input  rvCorePkg::aluOpE  aluOp,
    input  rvIsaPkg::funct3T  funct3,
    output rvIsaPkg::wordT    result,
    output logic              branchTaken
);

    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     eq;
    logic                     lt;
    logic                     ltu;

    // Low bits of B only
    assign shamt = opB[$clog2(`XLEN)-1:0];
    assign eq    = opA == opB;
    assign lt    = $signed(opA) < $signed(opB);
    assign ltu   = opA < opB;

    always_comb
    begin
        case (aluOp)
            rvCorePkg::ALU_ADD:   result = opA + opB;
            rvCorePkg::ALU_SUB:   result = opA - opB;
            rvCorePkg::ALU_SLL:   result = opA << shamt;
            rvCorePkg::ALU_SLT:   result = rvIsaPkg::wordT'(lt);
            rvCorePkg::ALU_SLTU:  result = rvIsaPkg::wordT'(ltu);
            rvCorePkg::ALU_XOR:   result = opA ^ opB;
            rvCorePkg::ALU_SRL:   result = opA >> shamt;
            rvCorePkg::ALU_SRA:   result = $signed(opA) >>> shamt;
            rvCorePkg::ALU_OR:    result = opA | opB;
            rvCorePkg::ALU_AND:   result = opA & opB;
            default:              result = opB;
        endcase
    end

    // BEQ BNE, BLT BGE, BLTU BGEU; gated by ctrl.branch in fetch
    always_comb
    begin
        case (funct3)
            3'b000:  branchTaken = eq;
            3'b001:  branchTaken = !eq;
            3'b100:  branchTaken = lt;
            3'b101:  branchTaken = !lt;
            3'b110:  branchTaken = ltu;
            3'b111:  branchTaken = !ltu;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// File: verilog/loadStoreUnit.sv
// Wishbone data-bus master for word loads and stores, one bus cycle per memStart
module loadStoreUnit (
    input  logic               clk,
    input  logic               rst,
    input  logic               memStart,
    input  rvCorePkg::ctrlT    ctrl,
    input  rvIsaPkg::wordT     addr,
    input  rvIsaPkg::wordT     storeData,
    output rvCorePkg::wbReqT   dbusReq,
    input  rvCorePkg::wbRspT   dbusRsp,
    output rvIsaPkg::wordT     loadData,
    output logic               memDone
);

    logic           busy;
    logic           weReg;
    rvIsaPkg::wordT adrReg;
    rvIsaPkg::wordT datReg;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            busy <= 1'b0;
        else if (memStart)
            busy <= 1'b1;
        else if (memDone)
            busy <= 1'b0;
    end

    // Request payload held for the whole cycle
    always_ff @(posedge clk)
    begin
        if (memStart)
        begin
            weReg  <= ctrl.memWrite;
            adrReg <= addr;
            datReg <= storeData;
        end
    end

    // Read data kept for writeback
    always_ff @(posedge clk)
    begin
        if (memDone && !weReg)
            loadData <= dbusRsp.dat;
    end

    assign memDone = busy && dbusRsp.ack;

    always_comb
    begin
        dbusReq.cyc = busy;
        dbusReq.stb = busy;
        dbusReq.we  = weReg;
        dbusReq.adr = adrReg;
        dbusReq.dat = datReg;
        dbusReq.sel = 4'b1111;
    end

    // Misaligned words are outside the supported subset
    wordAligned: assert property (@(posedge clk) disable iff (rst)
        dbusReq.cyc |-> dbusReq.adr[1:0] == 2'b00);

endmodule

// File: verilog/rvCore.sv
// Multi-cycle RV32I core top: step sequencer, retire record and block wiring
module rvCore (
    input  logic              clk,
    input  logic              rst,
    output rvCorePkg::wbReqT  ibusReq,
    input  rvCorePkg::wbRspT  ibusRsp,
    output rvCorePkg::wbReqT  dbusReq,
    input  rvCorePkg::wbRspT  dbusRsp,
    output rvCorePkg::retireT retire,
    output logic              halted
);

    rvCorePkg::seqStateE   state;
    rvCorePkg::seqStateE   nextState;
    rvCorePkg::ctrlT       ctrl;
    rvIsaPkg::instrFieldsT fields;
    rvIsaPkg::instrT       fetchedInstr;
    rvIsaPkg::instrT       instrReg;
    rvIsaPkg::wordT        pc;
    rvIsaPkg::wordT        pcPlus4;
    rvIsaPkg::wordT        imm;
    rvIsaPkg::wordT        rs1Data;
    rvIsaPkg::wordT        rs2Data;
    rvIsaPkg::wordT        opA;
    rvIsaPkg::wordT        opB;
    rvIsaPkg::wordT        aluResult;
    rvIsaPkg::wordT        loadData;
    rvIsaPkg::wordT        wbData;
    logic                  branchTaken;
    logic                  fetchStart;
    logic                  fetchDone;
    logic                  decodeLoad;
    logic                  memStart;
    logic                  memDone;
    logic                  pcUpdate;
    logic                  regWe;
    logic                  isMem;

    assign isMem = ctrl.memRead || ctrl.memWrite;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= rvCorePkg::SEQ_FETCH;
        else
            state <= nextState;
    end

    // FETCH and MEMORY wait on the bus, the others take one cycle
    always_comb
    begin
        nextState = state;
        case (state)
            rvCorePkg::SEQ_FETCH:
                if (fetchDone)
                    nextState = rvCorePkg::SEQ_DECODE;
            rvCorePkg::SEQ_DECODE:
                nextState = rvCorePkg::SEQ_EXECUTE;
            rvCorePkg::SEQ_EXECUTE:
                nextState = isMem ? rvCorePkg::SEQ_MEMORY : rvCorePkg::SEQ_WRITEBACK;
            rvCorePkg::SEQ_MEMORY:
                if (memDone)
                    nextState = rvCorePkg::SEQ_WRITEBACK;
            rvCorePkg::SEQ_WRITEBACK:
                nextState = ctrl.halt ? rvCorePkg::SEQ_HALTED : rvCorePkg::SEQ_FETCH;
            default:
                nextState = rvCorePkg::SEQ_HALTED;
        endcase
    end

    // Next fetch launched from WRITEBACK so the bus opens as FETCH begins
    // First fetch after reset is launched from FETCH itself
    assign fetchStart = (state == rvCorePkg::SEQ_WRITEBACK && !ctrl.halt) ||
                        (state == rvCorePkg::SEQ_FETCH && !ibusReq.cyc);
    assign decodeLoad = state == rvCorePkg::SEQ_DECODE;
    assign memStart   = state == rvCorePkg::SEQ_EXECUTE && isMem;
    assign pcUpdate   = state == rvCorePkg::SEQ_WRITEBACK;
    assign regWe      = pcUpdate && ctrl.regWrite;
    assign halted     = state == rvCorePkg::SEQ_HALTED;

    // Operand selection
    always_comb
    begin
        case (ctrl.aluSrcA)
            rvCorePkg::SRCA_PC:   opA = pc;
            rvCorePkg::SRCA_ZERO: opA = '0;
            default:              opA = rs1Data;
        endcase
    end

    assign opB = ctrl.opBImm ? imm : rs2Data;

    always_comb
    begin
        case (ctrl.wbSrc)
            rvCorePkg::WB_LOAD: wbData = loadData;
            rvCorePkg::WB_PC4:  wbData = pcPlus4;
            default:            wbData = aluResult;
        endcase
    end

    // Retire record, valid for the WRITEBACK cycle only
    always_comb
    begin
        retire.valid   = pcUpdate;
        retire.pc      = pc;
        retire.instr   = instrReg;
        retire.rdWe    = ctrl.regWrite;
        retire.rd      = fields.rd;
        retire.rdData  = wbData;
        retire.illegal = ctrl.illegal;
    end

    instrFetch fetchInst (
        .clk(clk), .rst(rst),
        .fetchStart(fetchStart), .pcUpdate(pcUpdate),
        .ctrl(ctrl), .imm(imm), .branchTaken(branchTaken), .aluResult(aluResult),
        .ibusReq(ibusReq), .ibusRsp(ibusRsp),
        .pc(pc), .pcPlus4(pcPlus4), .instr(fetchedInstr), .fetchDone(fetchDone)
    );

    decode decodeInst (
        .clk(clk), .rst(rst),
        .decodeLoad(decodeLoad), .nextInstruction(fetchedInstr),
        .fields(fields), .imm(imm), .ctrl(ctrl), .instrReg(instrReg)
    );

    regFile regInst (
        .clk(clk), .rst(rst),
        .rs1(fields.rs1), .rs2(fields.rs2),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .we(regWe), .rd(fields.rd), .wdata(wbData)
    );

    alu aluInst (
        .opA(opA), .opB(opB), .aluOp(ctrl.aluOp), .funct3(fields.funct3),
        .result(aluResult), .branchTaken(branchTaken)
    );

    loadStoreUnit lsuInst (
        .clk(clk), .rst(rst),
        .memStart(memStart), .ctrl(ctrl),
        .addr(aluResult), .storeData(rs2Data),
        .dbusReq(dbusReq), .dbusRsp(dbusRsp),
        .loadData(loadData), .memDone(memDone)
    );

    // Retire only in WRITEBACK and with both buses idle
    retireInWriteback: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> state == rvCorePkg::SEQ_WRITEBACK && !ibusReq.cyc && !dbusReq.cyc);

endmodule

// File: verification/wbMemModel.sv
// Wishbone classic slave memory for the core testbench, with optional LFSR-driven wait states
module wbMemModel #(
    parameter int          DEPTH = 128,
    parameter logic [31:0] SEED  = 32'd76311
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             waitsOn,
    input  rvCorePkg::wbReqT req,
    output rvCorePkg::wbRspT rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDX_BITS = $clog2(DEPTH);

    rvIsaPkg::wordT      mem [0:DEPTH-1];
    logic [31:0]         lfsr;
    logic [IDX_BITS-1:0] idx;
    logic                active;
    int                  waitLeft;

    // Fibonacci form, taps 32 22 2 1, new bit enters at the bottom
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Backdoor load
    task automatic writeWord(input int at, input rvIsaPkg::wordT w);
        mem[at] = w;
    endtask

    initial
    begin
        lfsr     = SEED;
        active   = 1'b0;
        waitLeft = 0;
        rsp      = '0;
        // Word index in the low half, so stray reads are easy to spot
        for (int i = 0; i < DEPTH; i++)
            mem[i] = {16'hBAD0, 16'(i)};
    end

    assign idx = req.adr[IDX_BITS+1:2];

    // Response moves on the falling edge, the core samples on the rising one
    always @(negedge clk)
    begin
        if (rst || !(req.cyc && req.stb) || rsp.ack)
        begin
            rsp.ack = 1'b0;
            active  = 1'b0;
        end
        else
        begin
            // New cycle: two LFSR bits give 0 to 3 wait states
            if (!active)
            begin
                active   = 1'b1;
                waitLeft = 0;
                if (waitsOn)
                begin
                    lfsr     = lfsrStep(lfsr);
                    waitLeft = int'(lfsr[0]);
                    lfsr     = lfsrStep(lfsr);
                    waitLeft = waitLeft + 2 * int'(lfsr[0]);
                end
            end
            if (waitLeft > 0)
                waitLeft = waitLeft - 1;
            else
            begin
                // Only the selected byte lanes are written
                if (req.we)
                begin
                    for (int b = 0; b < 4; b++)
                        if (req.sel[b])
                            mem[idx][8*b +: 8] = req.dat[8*b +: 8];
                end
                rsp.dat = mem[idx];
                rsp.ack = 1'b1;
            end
        end
    end

endmodule

// File: verification/rvCoreTb.sv
// Testbench for the RV32I core: runs the golden program twice, without and with bus wait states
module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    // Layout of the golden image, in words
    localparam int GOLDEN_WORDS    = 256;
    localparam int PROG_BASE       = 'h00;
    localparam int DATA_BASE       = 'h20;
    localparam int REGION_WORDS    = 32;
    localparam int COUNT_AT        = 'h40;
    localparam int TRACE_BASE      = 'h80;
    localparam int MAX_TRACE       = (GOLDEN_WORDS - TRACE_BASE) / 4;
    localparam int CYCLES_PER_LINE = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int PASSES          = 2;

    logic              clk;
    logic              rst;
    logic              waitsOn;
    rvCorePkg::wbReqT  ibusReq;
    rvCorePkg::wbRspT  ibusRsp;
    rvCorePkg::wbReqT  dbusReq;
    rvCorePkg::wbRspT  dbusRsp;
    rvCorePkg::retireT retire;
    logic              halted;

    rvIsaPkg::wordT golden [0:GOLDEN_WORDS-1];
    int             traceLen = 0;

    rvCore uut (
        .clk(clk), .rst(rst),
        .ibusReq(ibusReq), .ibusRsp(ibusRsp),
        .dbusReq(dbusReq), .dbusRsp(dbusRsp),
        .retire(retire), .halted(halted)
    );

    wbMemModel #(.DEPTH(128), .SEED(32'd76311)) instrMem (
        .clk(clk), .rst(rst), .waitsOn(waitsOn), .req(ibusReq), .rsp(ibusRsp)
    );

    wbMemModel #(.DEPTH(128), .SEED(32'd76311)) dataMem (
        .clk(clk), .rst(rst), .waitsOn(waitsOn), .req(dbusReq), .rsp(dbusRsp)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input rvIsaPkg::wordT exp,
                             input rvIsaPkg::wordT act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic checkReg(input string name, input rvIsaPkg::regIdxT exp,
                            input rvIsaPkg::regIdxT act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %s expected x%0d actual x%0d", name, exp, act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
    endtask

    // Program into the fetch model, data words into the data model
    task automatic loadMemories();
        for (int i = 0; i < REGION_WORDS; i++)
        begin
            instrMem.writeWord(PROG_BASE + i, golden[PROG_BASE + i]);
            dataMem.writeWord(DATA_BASE + i, golden[DATA_BASE + i]);
        end
    endtask

    // Memories reloaded under reset, so the second pass starts from the same image
    task automatic restartCore(input logic randomWaits);
        @(negedge clk);
        rst     = 1'b1;
        waitsOn = randomWaits;
        loadMemories();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    // One golden line: pc rd rdWe rdData
    task automatic checkRetire(input int pass, input int idx);
        int    at;
        string tag;
        at  = TRACE_BASE + 4 * idx;
        tag = $sformatf("pass %0d retire %0d", pass, idx);
        checkWord({tag, " pc"}, golden[at], retire.pc);
        checkWord({tag, " instr"}, golden[PROG_BASE + golden[at][31:2]], retire.instr);
        checkBit({tag, " rdWe"}, golden[at + 2][0], retire.rdWe);
        // rd and rdData carry meaning only when a register is written
        if (golden[at + 2][0])
        begin
            checkReg({tag, " rd"}, golden[at + 1][4:0], retire.rd);
            checkWord({tag, " rdData"}, golden[at + 3], retire.rdData);
        end
        // Every instruction in the image is supported
        checkBit({tag, " illegal"}, 1'b0, retire.illegal);
    endtask

    task automatic runPass(input int pass);
        int   idx;
        logic done;
        idx  = 0;
        done = 1'b0;
        restartCore(pass != 0);
        while (!done)
        begin
            @(posedge clk);
            if (retire.valid)
            begin
                if (idx >= traceLen)
                    abortRun($sformatf("pass %0d: core retired more than %0d instructions",
                                       pass, traceLen));
                checkRetire(pass, idx);
                idx++;
            end
            else if (halted)
                done = 1'b1;
        end
        if (idx != traceLen)
            abortRun($sformatf("pass %0d: core halted after %0d of %0d instructions",
                               pass, idx, traceLen));
        // Halted core stays quiet on both buses
        repeat (4)
        begin
            @(posedge clk);
            checkBit($sformatf("pass %0d halted held", pass), 1'b1, halted);
            checkBit($sformatf("pass %0d ibus idle after halt", pass), 1'b0, ibusReq.cyc);
            checkBit($sformatf("pass %0d dbus idle after halt", pass), 1'b0, dbusReq.cyc);
        end
    endtask

    // Budget grows with the trace length
    initial
    begin
        wait (traceLen > 0);
        repeat (PASSES * (traceLen * CYCLES_PER_LINE + RESET_CYCLES + 8)) @(posedge clk);
        abortRun("Watchdog expired: the core stopped retiring instructions");
    end

    initial
    begin
        clk     = 1'b0;
        rst     = 1'b1;
        waitsOn = 1'b0;
        // Word index in the low half marks slots the image leaves empty
        for (int i = 0; i < GOLDEN_WORDS; i++)
            golden[i] = {16'hDEAD, 16'(i)};
        $readmemh("verification/program_golden.txt", golden);
        if (golden[COUNT_AT] == 0 || golden[COUNT_AT] > MAX_TRACE)
            abortRun("Golden file is missing or its trace length is out of range");
        else
        begin
            traceLen = int'(golden[COUNT_AT]);
            // Pass 0 with immediate ack, pass 1 with random wait states
            for (int pass = 0; pass < PASSES; pass++)
                runPass(pass);
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: verification/program_golden.txt
// $readmemh image, hex tokens: @00 program words, @20 initial data words, @40 trace length
// @80 expected retires, four tokens each as pc rd rdWe rdData, two retires per line
@00
00500093 FFD00113 002081B3 40208233  // 00 addi addi add sub
001122B3 00113333 0020C3B3 40115413  // 10 slt sltu xor srai
01C15493 00409513 401155B3 12345637  // 20 srli slli sra lui
00001697 08002703 08402223 08402783  // 30 auipc lw sw lw
00700013 00100833 01008463 00100A13  // 40 addi x0 then add beq skipped
01009463 00114463 00200A13 00117463  // 50 bne blt skipped bgeu
00300A13 010008EF 00A0E933 007979B3  // 60 skipped jal or and
00000073 00188A67                    // 70 ecall jalr
@20
12345678 CAFEF00D
@40
0000001B
@80
00000000 01 1 00000005  00000004 02 1 FFFFFFFD
00000008 03 1 00000002  0000000C 04 1 00000008
00000010 05 1 00000001  00000014 06 1 00000000
00000018 07 1 FFFFFFF8  0000001C 08 1 FFFFFFFE
00000020 09 1 0000000F  00000024 0A 1 00000050
00000028 0B 1 FFFFFFFF  0000002C 0C 1 12345000
00000030 0D 1 00001030  00000034 0E 1 12345678
00000038 00 0 00000000  0000003C 0F 1 00000008
00000040 00 1 00000007  00000044 10 1 00000005
00000048 00 0 00000000  00000050 00 0 00000000
00000054 00 0 00000000  0000005C 00 0 00000000
00000064 11 1 00000068  00000074 14 1 00000078
00000068 12 1 00000055  0000006C 13 1 00000050
00000070 00 0 00000000

// File: files.f
+incdir+include
verilog/rvIsaPkg.sv
verilog/rvCorePkg.sv
verilog/instrFetch.sv
verilog/decode.sv
verilog/regFile.sv
verilog/alu.sv
verilog/loadStoreUnit.sv
verilog/rvCore.sv
verification/wbMemModel.sv
verification/rvCoreTb.sv
